// File: hdl/dpe_pkg.sv
// ======================================================================
// datapath constants of the dot product engine
// lane count, element, product and result widths
// buffer depth, index and length widths, pipeline latency
// controller state enum
// ======================================================================
package dpe_pkg;

    // four signed int8 lanes packed into one 32-bit word
    localparam int LANES = 4;
    localparam int IPREC = 8;
    localparam int MPREC = 2 * IPREC;
    localparam int OPREC = 32;
    localparam int DATAW = LANES * IPREC;

    // word buffers and job length
    localparam int DEPTH = 16;
    localparam int ADDRW = 4;
    // LEN runs 1..16 so it needs one bit more than the index
    localparam int LENW  = 5;

    // i_valid to o_valid of the dpe
    localparam int DPE_LAT = 4;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } ctrl_state_e;

endpackage

// File: hdl/csr_pkg.sv
// ======================================================================
// APB register map of the dot product accelerator
// bus widths, register offsets, buffer windows
// register select enum and CTRL / STATUS bit positions
// ======================================================================
package csr_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register offsets
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_LEN    = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_RESULT = 8'h0C;
    // 16-word windows, 0x40..0x7C and 0x80..0xBC
    localparam logic [APB_AW-1:0] ADDR_BUFA   = 8'h40;
    localparam logic [APB_AW-1:0] ADDR_BUFB   = 8'h80;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_CTRL,
        SEL_STATUS,
        SEL_LEN,
        SEL_RESULT,
        SEL_BUFA,
        SEL_BUFB
    } reg_sel_e;

    localparam int CTRL_START = 0;
    localparam int ST_BUSY    = 0;
    localparam int ST_DONE    = 1;

endpackage

// File: hdl/dpe.sv
`timescale 1ns/1ns
// ======================================================================
// four-lane signed int8 dot product engine
// input register, lane multiply, two-stage registered adder tree
// valid shift register alongside the data, latency of four cycles
// ======================================================================
module dpe (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_valid,
    input  logic [dpe_pkg::DATAW-1:0]        i_dataa,
    input  logic [dpe_pkg::DATAW-1:0]        i_datab,
    output logic                             o_valid,
    output logic signed [dpe_pkg::OPREC-1:0] o_result
);
    import dpe_pkg::*;

    // lane views of the packed words
    logic signed [IPREC-1:0] dataa [LANES];
    logic signed [IPREC-1:0] datab [LANES];

    // pipeline registers
    logic signed [IPREC-1:0] r_dataa [LANES];
    logic signed [IPREC-1:0] r_datab [LANES];
    logic signed [MPREC-1:0] r_mrslt [LANES];
    logic signed [OPREC-1:0] r_arslt_s1 [LANES/2];
    logic signed [OPREC-1:0] r_arslt_s2;
    logic [DPE_LAT-1:0]      r_vld;

    // unpipelined sum of the lanes at the input
    logic signed [OPREC-1:0] ref_sum;

    // lane 0 sits in the low byte
    for (genvar j = 0; j < LANES; j++) begin : g_split
        assign dataa[j] = i_dataa[j*IPREC +: IPREC];
        assign datab[j] = i_datab[j*IPREC +: IPREC];
    end

    always_ff @(posedge clk) begin
        // stages 1 and 2 capture then multiply
        for (int i = 0; i < LANES; i++) begin
            r_dataa[i] <= dataa[i];
            r_datab[i] <= datab[i];
            r_mrslt[i] <= r_dataa[i] * r_datab[i];
        end
        // stage 3 adds pairs sign extended to the result width
        for (int i = 0; i < LANES/2; i++) begin
            r_arslt_s1[i] <= r_mrslt[2*i] + r_mrslt[2*i+1];
        end
        // stage 4 forms the final sum
        r_arslt_s2 <= r_arslt_s1[0] + r_arslt_s1[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_vld <= '0;
        end else begin
            r_vld <= {r_vld[DPE_LAT-2:0], i_valid};
        end
    end

    assign o_result = r_arslt_s2;
    assign o_valid  = r_vld[DPE_LAT-1];

    always_comb begin
        ref_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            ref_sum = ref_sum + dataa[i] * datab[i];
        end
    end

    // a result only leaves for a word that entered DPE_LAT cycles before
    // and the tree output lines up with that word
    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst)
        o_valid |-> ($past(i_valid, DPE_LAT) && o_result == $past(ref_sum, DPE_LAT))
    );

endmodule

// File: hdl/vec_buffer.sv
`timescale 1ns/1ns
// ======================================================================
// 16 x 32-bit word buffer
// one write port, one registered read port, single clock
// ======================================================================
module vec_buffer (
    input  logic                      clk,
    input  logic                      i_we,
    input  logic [dpe_pkg::ADDRW-1:0] i_waddr,
    input  logic [dpe_pkg::DATAW-1:0] i_wdata,
    input  logic [dpe_pkg::ADDRW-1:0] i_raddr,
    output logic [dpe_pkg::DATAW-1:0] o_rdata
);
    import dpe_pkg::*;

    logic [DATAW-1:0] mem [DEPTH];
    logic [DATAW-1:0] r_rdata;

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // data follows the address by one cycle
        r_rdata <= mem[i_raddr];
    end

    assign o_rdata = r_rdata;

endmodule

// File: hdl/word_counter.sv
`timescale 1ns/1ns
// ======================================================================
// word counter with clear and increment
// last flag at LEN-1, increment on the last word wraps to 0
// ======================================================================
module word_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_clear,
    input  logic                      i_inc,
    input  logic [dpe_pkg::LENW-1:0]  i_len,
    output logic [dpe_pkg::ADDRW-1:0] o_count,
    output logic                      o_last
);
    import dpe_pkg::*;

    logic [ADDRW-1:0] r_count;

    assign o_last  = (LENW'(r_count) == i_len - LENW'(1));
    assign o_count = r_count;

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            r_count <= '0;
        end else if (i_inc) begin
            if (o_last) begin
                r_count <= '0;
            end else begin
                r_count <= r_count + 1'b1;
            end
        end
    end

    // the sequencer never counts beyond the job length
    a_inc_in_range: assert property (
        @(posedge clk) disable iff (rst) (i_inc && !i_clear) |-> (LENW'(r_count) < i_len)
    );

endmodule

// File: hdl/dot_ctrl_fsm.sv
`timescale 1ns/1ns
// ======================================================================
// job controller FSM, IDLE -> RUN -> DRAIN -> DONE
// one buffer read per RUN cycle, delayed one cycle as dpe valid
// done pulse in the DONE cycle
// ======================================================================
module dot_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic i_start,
    input  logic i_issue_last,
    input  logic i_retire_last,
    input  logic i_res_valid,
    output logic o_busy,
    output logic o_issue_clear,
    output logic o_issue_inc,
    output logic o_retire_clear,
    output logic o_data_valid,
    output logic o_done
);
    import dpe_pkg::*;

    ctrl_state_e r_state;
    ctrl_state_e nxt_state;
    logic        r_data_valid;

    always_comb begin
        nxt_state = r_state;
        case (r_state)
            IDLE: begin
                if (i_start) begin
                    nxt_state = RUN;
                end
            end
            // LEN cycles until the issue counter flags the last word
            RUN: begin
                if (i_issue_last) begin
                    nxt_state = DRAIN;
                end
            end
            // wait for the last word out of the dpe
            DRAIN: begin
                if (i_retire_last && i_res_valid) begin
                    nxt_state = DONE;
                end
            end
            // accumulator holds the final sum here
            DONE:    nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state      <= IDLE;
            r_data_valid <= 1'b0;
        end else begin
            r_state      <= nxt_state;
            // buffer read data lands one cycle after the issue
            r_data_valid <= o_issue_inc;
        end
    end

    // both counters restart with the job
    assign o_issue_clear  = (r_state == IDLE) && i_start;
    assign o_retire_clear = (r_state == IDLE) && i_start;
    assign o_issue_inc    = (r_state == RUN);
    assign o_busy         = (r_state != IDLE);
    assign o_data_valid   = r_data_valid;
    assign o_done         = (r_state == DONE);

    // the APB block refuses a start while a job runs
    a_start_in_idle: assert property (
        @(posedge clk) disable iff (rst) i_start |-> (r_state == IDLE)
    );

    // the last result only arrives once every word was issued
    a_last_in_drain: assert property (
        @(posedge clk) disable iff (rst) (i_retire_last && i_res_valid) |-> (r_state == DRAIN)
    );

endmodule

// File: hdl/dot_accum.sv
`timescale 1ns/1ns
// ======================================================================
// accumulator of dpe partial sums
// 32-bit signed, wraps modulo 2^32, cleared at job start
// ======================================================================
module dot_accum (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_clear,
    input  logic                             i_valid,
    input  logic signed [dpe_pkg::OPREC-1:0] i_psum,
    output logic signed [dpe_pkg::OPREC-1:0] o_sum
);
    import dpe_pkg::*;

    logic signed [OPREC-1:0] r_sum;

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            r_sum <= '0;
        end else if (i_valid) begin
            // overflow simply wraps
            r_sum <= r_sum + i_psum;
        end
    end

    assign o_sum = r_sum;

endmodule

// File: hdl/dot_csr_apb.sv
`timescale 1ns/1ns
// ======================================================================
// APB3 slave of the dot product accelerator
// address decode, error responses, LEN and sticky done registers
// buffer write decode and idle buffer readback
// ======================================================================
module dot_csr_apb (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [csr_pkg::APB_AW-1:0]       i_paddr,
    input  logic [csr_pkg::APB_DW-1:0]       i_pwdata,
    output logic [csr_pkg::APB_DW-1:0]       o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr,
    input  logic                             i_busy,
    input  logic                             i_done,
    input  logic signed [dpe_pkg::OPREC-1:0] i_result,
    input  logic [dpe_pkg::DATAW-1:0]        i_buf_rdata_a,
    input  logic [dpe_pkg::DATAW-1:0]        i_buf_rdata_b,
    output logic                             o_start,
    output logic [dpe_pkg::LENW-1:0]         o_len,
    output logic                             o_we_a,
    output logic                             o_we_b,
    output logic [dpe_pkg::ADDRW-1:0]        o_waddr,
    output logic [dpe_pkg::DATAW-1:0]        o_wdata,
    output logic [dpe_pkg::ADDRW-1:0]        o_raddr
);
    import dpe_pkg::*;
    import csr_pkg::*;

    reg_sel_e        sel;
    logic            access;
    logic            err;
    logic            wr_ok;
    logic            r_busy_q;
    logic            r_done;
    logic [LENW-1:0] r_len;

    // buffer windows need an aligned word address
    always_comb begin
        sel = SEL_NONE;
        if (i_paddr[1:0] == 2'b00 &&
            i_paddr[APB_AW-1:ADDRW+2] == ADDR_BUFA[APB_AW-1:ADDRW+2]) begin
            sel = SEL_BUFA;
        end else if (i_paddr[1:0] == 2'b00 &&
                     i_paddr[APB_AW-1:ADDRW+2] == ADDR_BUFB[APB_AW-1:ADDRW+2]) begin
            sel = SEL_BUFB;
        end else begin
            case (i_paddr)
                ADDR_CTRL:   sel = SEL_CTRL;
                ADDR_STATUS: sel = SEL_STATUS;
                ADDR_LEN:    sel = SEL_LEN;
                ADDR_RESULT: sel = SEL_RESULT;
                default:     sel = SEL_NONE;
            endcase
        end
    end

    // error rules, an erroring access has no effect
    always_comb begin
        err = 1'b0;
        case (sel)
            SEL_CTRL:   err = i_pwrite && i_pwdata[CTRL_START] && i_busy;
            SEL_STATUS: err = i_pwrite;
            SEL_RESULT: err = i_pwrite;
            SEL_LEN:    err = i_pwrite && (i_busy || i_pwdata == '0 || i_pwdata > DEPTH);
            // readback is stale if the FSM held the read port in setup
            SEL_BUFA,
            SEL_BUFB:   err = i_pwrite ? i_busy : (i_busy || r_busy_q);
            default:    err = 1'b1;
        endcase
    end

    assign access    = i_psel && i_penable;
    assign wr_ok     = access && i_pwrite && !err;
    assign o_pready  = 1'b1;
    assign o_pslverr = access && err;

    // start pulse in the access cycle, FSM leaves IDLE at its end
    assign o_start = wr_ok && (sel == SEL_CTRL) && i_pwdata[CTRL_START];
    assign o_we_a  = wr_ok && (sel == SEL_BUFA);
    assign o_we_b  = wr_ok && (sel == SEL_BUFB);
    assign o_waddr = i_paddr[ADDRW+1:2];
    assign o_wdata = i_pwdata;
    // address seen in setup, data returned in access
    assign o_raddr = i_paddr[ADDRW+1:2];
    assign o_len   = r_len;

    always_comb begin
        o_prdata = '0;
        if (!err) begin
            case (sel)
                SEL_STATUS: begin
                    o_prdata[ST_BUSY] = i_busy;
                    o_prdata[ST_DONE] = r_done;
                end
                SEL_LEN:    o_prdata = APB_DW'(r_len);
                SEL_RESULT: o_prdata = i_result;
                SEL_BUFA:   o_prdata = i_buf_rdata_a;
                SEL_BUFB:   o_prdata = i_buf_rdata_b;
                default:    o_prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_len    <= LENW'(DEPTH);
            r_done   <= 1'b0;
            r_busy_q <= 1'b0;
        end else begin
            r_busy_q <= i_busy;
            if (wr_ok && sel == SEL_LEN) begin
                r_len <= i_pwdata[LENW-1:0];
            end
            // sticky until the next job starts
            if (o_start) begin
                r_done <= 1'b0;
            end else if (i_done) begin
                r_done <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/dot_engine_top.sv
`timescale 1ns/1ns
// ======================================================================
// top level of the APB dot product accelerator
// APB slave, A and B word buffers, issue and retire counters
// job FSM, dpe and accumulator, buffer read address select
// ======================================================================
module dot_engine_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_psel,
    input  logic                       i_penable,
    input  logic                       i_pwrite,
    input  logic [csr_pkg::APB_AW-1:0] i_paddr,
    input  logic [csr_pkg::APB_DW-1:0] i_pwdata,
    output logic [csr_pkg::APB_DW-1:0] o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr
);
    import dpe_pkg::*;

    logic                    busy;
    logic                    done;
    logic                    start;
    logic [LENW-1:0]         len;
    logic                    we_a;
    logic                    we_b;
    logic [ADDRW-1:0]        waddr;
    logic [DATAW-1:0]        wdata;
    logic [ADDRW-1:0]        csr_raddr;
    logic [ADDRW-1:0]        buf_raddr;
    logic [DATAW-1:0]        rdata_a;
    logic [DATAW-1:0]        rdata_b;
    logic                    issue_clear;
    logic                    issue_inc;
    logic [ADDRW-1:0]        issue_count;
    logic                    issue_last;
    logic                    retire_clear;
    logic                    retire_last;
    logic                    data_valid;
    logic                    dpe_valid;
    logic signed [OPREC-1:0] dpe_result;
    logic signed [OPREC-1:0] acc_sum;

    dot_csr_apb u_csr (
        .clk           (clk),
        .rst           (rst),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .i_busy        (busy),
        .i_done        (done),
        .i_result      (acc_sum),
        .i_buf_rdata_a (rdata_a),
        .i_buf_rdata_b (rdata_b),
        .o_start       (start),
        .o_len         (len),
        .o_we_a        (we_a),
        .o_we_b        (we_b),
        .o_waddr       (waddr),
        .o_wdata       (wdata),
        .o_raddr       (csr_raddr)
    );

    // the FSM owns the read port during a job
    assign buf_raddr = busy ? issue_count : csr_raddr;

    vec_buffer u_buf_a (
        .clk     (clk),
        .i_we    (we_a),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .i_raddr (buf_raddr),
        .o_rdata (rdata_a)
    );

    vec_buffer u_buf_b (
        .clk     (clk),
        .i_we    (we_b),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .i_raddr (buf_raddr),
        .o_rdata (rdata_b)
    );

    word_counter u_issue_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_clear (issue_clear),
        .i_inc   (issue_inc),
        .i_len   (len),
        .o_count (issue_count),
        .o_last  (issue_last)
    );

    // counts results out of the dpe
    word_counter u_retire_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_clear (retire_clear),
        .i_inc   (dpe_valid),
        .i_len   (len),
        .o_count (),
        .o_last  (retire_last)
    );

    dot_ctrl_fsm u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_start        (start),
        .i_issue_last   (issue_last),
        .i_retire_last  (retire_last),
        .i_res_valid    (dpe_valid),
        .o_busy         (busy),
        .o_issue_clear  (issue_clear),
        .o_issue_inc    (issue_inc),
        .o_retire_clear (retire_clear),
        .o_data_valid   (data_valid),
        .o_done         (done)
    );

    dpe u_dpe (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (data_valid),
        .i_dataa  (rdata_a),
        .i_datab  (rdata_b),
        .o_valid  (dpe_valid),
        .o_result (dpe_result)
    );

    dot_accum u_accum (
        .clk     (clk),
        .rst     (rst),
        .i_clear (start),
        .i_valid (dpe_valid),
        .i_psum  (dpe_result),
        .o_sum   (acc_sum)
    );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns
// ======================================================================
// testbench clock and reset generator
// 40 ns clock, synchronous reset held for 5 rising edges
// ======================================================================
module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD/2) o_clk = ~o_clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// File: test/tb_dot_engine.sv
`timescale 1ns/1ns
// ======================================================================
// table-driven APB testbench of the dot product accelerator
// APB access tasks, buffer load and readback, reference model
// error response probes, STATUS polling and a watchdog
// ======================================================================
module tb_dot_engine;
    import dpe_pkg::*;
    import csr_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 5;
    localparam int NROWS       = 5;
    localparam int POLL_MAX    = 4 * DEPTH;
    // per job bound of 40 x max LEN cycles, plus reset
    localparam int WATCHDOG_NS = (NROWS * 40 * DEPTH + RST_CYCLES) * CLK_PERIOD;

    typedef enum int {FILL_RAND, FILL_NEG, FILL_MAX} fill_e;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    integer           seed;
    int               n_checks;
    int               val_errors;
    int               other_errors;
    logic [DATAW-1:0] a_words [DEPTH];
    logic [DATAW-1:0] b_words [DEPTH];

    // one row per job and the jobs run back to back
    string row_name      [NROWS] = '{"rand_len16", "rand_len7", "rand_len1",
                                     "neg_sq_len16", "max_neg_len16"};
    int    row_len       [NROWS] = '{16, 7, 1, 16, 16};
    fill_e row_fill      [NROWS] = '{FILL_RAND, FILL_RAND, FILL_RAND, FILL_NEG, FILL_MAX};
    // -128 x -128 x 64 lanes, and 127 x -128 x 64 lanes
    bit    row_fixed     [NROWS] = '{0, 0, 0, 1, 1};
    int    row_expect    [NROWS] = '{0, 0, 0, 1048576, -1040384};
    // accesses while busy, then an idle LEN write and its pslverr
    bit    row_busy_prb  [NROWS] = '{1, 0, 0, 0, 1};
    int    row_probe_len [NROWS] = '{0, 17, 9, 1, 31};
    bit    row_probe_err [NROWS] = '{1, 1, 0, 0, 1};

    tb_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    dot_engine_top u_dot_engine_top (
        .clk       (clk),
        .rst       (rst),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            val_errors++;
        end
    endtask

    // setup on one falling edge, access on the next
    task automatic bus_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // settled long before the completing rising edge
        #1;
        rdata = prdata;
        err   = pslverr;
        expect_equal("pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input string name, input logic [APB_AW-1:0] addr,
                             input logic [APB_DW-1:0] data, input logic exp_err);
        logic [APB_DW-1:0] rdata;
        logic              err;
        bus_access(1'b1, addr, data, rdata, err);
        expect_equal({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic read_reg(input string name, input logic [APB_AW-1:0] addr,
                            input logic exp_err, output logic [APB_DW-1:0] data);
        logic err;
        bus_access(1'b0, addr, '0, data, err);
        expect_equal({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic read_check(input string name, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] exp);
        logic [APB_DW-1:0] data;
        read_reg(name, addr, 1'b0, data);
        expect_equal(name, exp, data);
    endtask

    // sum of signed lane products over len words wrapping at 32 bits
    function automatic logic [31:0] model_result(input int len);
        int                      acc;
        int                      prod;
        logic signed [IPREC-1:0] ea;
        logic signed [IPREC-1:0] eb;
        acc = 0;
        for (int w = 0; w < len; w++) begin
            for (int l = 0; l < LANES; l++) begin
                ea   = a_words[w][l*IPREC +: IPREC];
                eb   = b_words[w][l*IPREC +: IPREC];
                prod = ea * eb;
                acc  = acc + prod;
            end
        end
        return acc;
    endfunction

    task automatic load_vectors(input int r);
        for (int i = 0; i < row_len[r]; i++) begin
            case (row_fill[r])
                FILL_NEG: begin
                    a_words[i] = 32'h8080_8080;
                    b_words[i] = 32'h8080_8080;
                end
                FILL_MAX: begin
                    a_words[i] = 32'h7f7f_7f7f;
                    b_words[i] = 32'h8080_8080;
                end
                default: begin
                    a_words[i] = $random(seed);
                    b_words[i] = $random(seed);
                end
            endcase
            write_reg({row_name[r], " write A"}, ADDR_BUFA + APB_AW'(4*i), a_words[i], 1'b0);
            write_reg({row_name[r], " write B"}, ADDR_BUFB + APB_AW'(4*i), b_words[i], 1'b0);
        end
        // idle readback of both buffers
        for (int i = 0; i < row_len[r]; i++) begin
            read_check({row_name[r], " readback A"}, ADDR_BUFA + APB_AW'(4*i), a_words[i]);
            read_check({row_name[r], " readback B"}, ADDR_BUFB + APB_AW'(4*i), b_words[i]);
        end
    endtask

    task automatic wait_for_done(input string name);
        logic [APB_DW-1:0] status;
        bit                seen;
        seen = 1'b0;
        for (int p = 0; p < POLL_MAX && !seen; p++) begin
            read_reg({name, " poll status"}, ADDR_STATUS, 1'b0, status);
            seen = status[ST_DONE];
        end
        assert (seen) else begin
            $display("%s: STATUS.done did not rise within %0d polls", name, POLL_MAX);
            other_errors++;
        end
    endtask

    task automatic run_row(input int r);
        logic [APB_DW-1:0] data;
        logic [APB_DW-1:0] exp_res;
        string             nm;
        nm = row_name[r];
        load_vectors(r);
        exp_res = model_result(row_len[r]);
        write_reg({nm, " len"}, ADDR_LEN, row_len[r], 1'b0);
        read_check({nm, " len readback"}, ADDR_LEN, row_len[r]);
        write_reg({nm, " start"}, ADDR_CTRL, 32'h1 << CTRL_START, 1'b0);
        // sticky done from the previous job is gone
        read_reg({nm, " status after start"}, ADDR_STATUS, 1'b0, data);
        expect_equal({nm, " done cleared"}, 32'd0, 32'(data[ST_DONE]));
        if (row_busy_prb[r]) begin
            write_reg({nm, " start while busy"}, ADDR_CTRL, 32'h1 << CTRL_START, 1'b1);
            write_reg({nm, " len while busy"}, ADDR_LEN, 32'd5, 1'b1);
            write_reg({nm, " buffer write while busy"}, ADDR_BUFA, ~a_words[0], 1'b1);
            read_reg({nm, " buffer read while busy"}, ADDR_BUFB, 1'b1, data);
        end
        wait_for_done(nm);
        // busy low once done is seen
        read_check({nm, " status at end"}, ADDR_STATUS, 32'h1 << ST_DONE);
        read_check({nm, " result"}, ADDR_RESULT, exp_res);
        if (row_fixed[r]) begin
            read_check({nm, " fixed result"}, ADDR_RESULT, row_expect[r]);
        end
        if (row_busy_prb[r]) begin
            read_check({nm, " buffer kept"}, ADDR_BUFA, a_words[0]);
        end
        write_reg({nm, " write to result"}, ADDR_RESULT, 32'h5a5a_5a5a, 1'b1);
        read_check({nm, " result kept"}, ADDR_RESULT, exp_res);
        read_check({nm, " len kept"}, ADDR_LEN, row_len[r]);
        write_reg({nm, " len probe"}, ADDR_LEN, row_probe_len[r], row_probe_err[r]);
        read_check({nm, " len after probe"}, ADDR_LEN,
                   row_probe_err[r] ? row_len[r] : row_probe_len[r]);
    endtask

    initial begin
        logic [APB_DW-1:0] data;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        seed         = 32'h5169d92f;
        n_checks     = 0;
        val_errors   = 0;
        other_errors = 0;
        wait (rst === 1'b0);
        read_check("reset status", ADDR_STATUS, 32'h0);
        read_check("reset result", ADDR_RESULT, 32'h0);
        read_check("reset len", ADDR_LEN, 32'(DEPTH));
        // holes in the map
        write_reg("unmapped write", 8'h10, 32'hffff_ffff, 1'b1);
        read_reg("unmapped read", 8'hC0, 1'b1, data);
        read_check("len after unmapped", ADDR_LEN, 32'(DEPTH));
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the jobs finished", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
hdl/dpe_pkg.sv
hdl/csr_pkg.sv
hdl/dpe.sv
hdl/vec_buffer.sv
hdl/word_counter.sv
hdl/dot_ctrl_fsm.sv
hdl/dot_accum.sv
hdl/dot_csr_apb.sv
hdl/dot_engine_top.sv
test/tb_clk_gen.sv
test/tb_dot_engine.sv

// File: Bender.yml
package:
  name: dot_engine

sources:
  - files:
      - hdl/dpe_pkg.sv
      - hdl/csr_pkg.sv
      - hdl/dpe.sv
      - hdl/vec_buffer.sv
      - hdl/word_counter.sv
      - hdl/dot_ctrl_fsm.sv
      - hdl/dot_accum.sv
      - hdl/dot_csr_apb.sv
      - hdl/dot_engine_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_dot_engine.sv
